/* compile.f */
+incdir+hw
hw/axi_pkg.sv
hw/aw_router.sv
hw/w_router.sv
hw/b_router.sv
hw/axi_write_xbar.sv
verif/axi_write_xbar_checker.sv
verif/axi_write_xbar_tb.sv

/* hw/aw_router.sv */
`default_nettype none

`include "axi_consts.svh"

module aw_router
  import axi_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  // Master
  input  axi_addr_t            awaddr_m,
  input  axi_len_t             awlen_m,
  input  logic                 awvalid_m,
  output logic                 awready_m,
  // Lock from the W path
  input  write_data_arb_lock_t write_data_arb_lock,
  // Slave 0
  output axi_addr_t            awaddr_s0,
  output axi_len_t             awlen_s0,
  output logic                 awvalid_s0,
  input  logic                 awready_s0,
  // Slave 1
  output axi_addr_t            awaddr_s1,
  output axi_len_t             awlen_s1,
  output logic                 awvalid_s1,
  input  logic                 awready_s1,
  // Slave 2
  output axi_addr_t            awaddr_s2,
  output axi_len_t             awlen_s2,
  output logic                 awvalid_s2,
  input  logic                 awready_s2
);

  logic [1:0] region;
  logic [2:0] aw_sel;
  logic       aw_taken;
  logic       aw_open;

  assign region = awaddr_m[`AXI_SEL_MSB:`AXI_SEL_LSB];

  // Region 3 falls to the default slave
  always_comb begin
    case (region)
      2'd0:    aw_sel = 3'b001;
      2'd1:    aw_sel = 3'b010;
      default: aw_sel = 3'b100;
    endcase
  end

  // Only one write in flight
  assign aw_open = (write_data_arb_lock == WLOCK_NO) && !aw_taken;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_taken <= 1'b0;
    end else if (awvalid_m && awready_m) begin
      aw_taken <= 1'b1;
    end else if (write_data_arb_lock != WLOCK_NO) begin
      aw_taken <= 1'b0;
    end
  end

  assign awvalid_s0 = aw_open & aw_sel[0] & awvalid_m;
  assign awvalid_s1 = aw_open & aw_sel[1] & awvalid_m;
  assign awvalid_s2 = aw_open & aw_sel[2] & awvalid_m;

  assign awaddr_s0 = aw_sel[0] ? awaddr_m : '0;
  assign awaddr_s1 = aw_sel[1] ? awaddr_m : '0;
  assign awaddr_s2 = aw_sel[2] ? awaddr_m : '0;

  assign awlen_s0 = aw_sel[0] ? awlen_m : '0;
  assign awlen_s1 = aw_sel[1] ? awlen_m : '0;
  assign awlen_s2 = aw_sel[2] ? awlen_m : '0;

  // Ready comes back from the decoded slave alone
  assign awready_m = aw_open & |(aw_sel & {awready_s2, awready_s1, awready_s0});

endmodule

`default_nettype wire

/* hw/axi_consts.svh */
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// Bus widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_LEN_BITS  8

// Address bits that pick the slave
`define AXI_SEL_LSB 16
`define AXI_SEL_MSB 17

`endif

/* hw/axi_pkg.sv */
`default_nettype none

`include "axi_consts.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;
  typedef logic [1:0]                axi_resp_t;

  // Which slave owns the write, and whether it waits for B
  typedef enum logic [2:0] {
    WLOCK_NO       = 3'd0,
    WLOCK_S0       = 3'd1,
    WLOCK_S1       = 3'd2,
    WLOCK_S2       = 3'd3,
    WLOCK_S0_WRESP = 3'd4,
    WLOCK_S1_WRESP = 3'd5,
    WLOCK_S2_WRESP = 3'd6
  } write_data_arb_lock_t;

endpackage

`default_nettype wire

/* hw/axi_write_xbar.sv */
`default_nettype none

module axi_write_xbar
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  // Master
  input  axi_addr_t awaddr_m,
  input  axi_len_t  awlen_m,
  input  logic      awvalid_m,
  output logic      awready_m,
  input  axi_data_t wdata_m,
  input  axi_strb_t wstrb_m,
  input  logic      wlast_m,
  input  logic      wvalid_m,
  output logic      wready_m,
  output axi_resp_t bresp_m,
  output logic      bvalid_m,
  input  logic      bready_m,
  // Slave 0
  output axi_addr_t awaddr_s0,
  output axi_len_t  awlen_s0,
  output logic      awvalid_s0,
  input  logic      awready_s0,
  output axi_data_t wdata_s0,
  output axi_strb_t wstrb_s0,
  output logic      wlast_s0,
  output logic      wvalid_s0,
  input  logic      wready_s0,
  input  axi_resp_t bresp_s0,
  input  logic      bvalid_s0,
  output logic      bready_s0,
  // Slave 1
  output axi_addr_t awaddr_s1,
  output axi_len_t  awlen_s1,
  output logic      awvalid_s1,
  input  logic      awready_s1,
  output axi_data_t wdata_s1,
  output axi_strb_t wstrb_s1,
  output logic      wlast_s1,
  output logic      wvalid_s1,
  input  logic      wready_s1,
  input  axi_resp_t bresp_s1,
  input  logic      bvalid_s1,
  output logic      bready_s1,
  // Slave 2, also the default slave
  output axi_addr_t awaddr_s2,
  output axi_len_t  awlen_s2,
  output logic      awvalid_s2,
  input  logic      awready_s2,
  output axi_data_t wdata_s2,
  output axi_strb_t wstrb_s2,
  output logic      wlast_s2,
  output logic      wvalid_s2,
  input  logic      wready_s2,
  input  axi_resp_t bresp_s2,
  input  logic      bvalid_s2,
  output logic      bready_s2
);

  write_data_arb_lock_t write_data_arb_lock;

  aw_router u_aw_router (
    .clk                 (clk),
    .rstn                (rstn),
    .awaddr_m            (awaddr_m),
    .awlen_m             (awlen_m),
    .awvalid_m           (awvalid_m),
    .awready_m           (awready_m),
    .write_data_arb_lock (write_data_arb_lock),
    .awaddr_s0           (awaddr_s0),
    .awlen_s0            (awlen_s0),
    .awvalid_s0          (awvalid_s0),
    .awready_s0          (awready_s0),
    .awaddr_s1           (awaddr_s1),
    .awlen_s1            (awlen_s1),
    .awvalid_s1          (awvalid_s1),
    .awready_s1          (awready_s1),
    .awaddr_s2           (awaddr_s2),
    .awlen_s2            (awlen_s2),
    .awvalid_s2          (awvalid_s2),
    .awready_s2          (awready_s2)
  );

  // Owns the lock
  w_router u_w_router (
    .clk                 (clk),
    .rstn                (rstn),
    .wdata_m             (wdata_m),
    .wstrb_m             (wstrb_m),
    .wlast_m             (wlast_m),
    .wvalid_m            (wvalid_m),
    .wready_m            (wready_m),
    .bvalid_m            (bvalid_m),
    .bready_m            (bready_m),
    .awvalid_s0          (awvalid_s0),
    .awready_s0          (awready_s0),
    .wdata_s0            (wdata_s0),
    .wstrb_s0            (wstrb_s0),
    .wlast_s0            (wlast_s0),
    .wvalid_s0           (wvalid_s0),
    .wready_s0           (wready_s0),
    .awvalid_s1          (awvalid_s1),
    .awready_s1          (awready_s1),
    .wdata_s1            (wdata_s1),
    .wstrb_s1            (wstrb_s1),
    .wlast_s1            (wlast_s1),
    .wvalid_s1           (wvalid_s1),
    .wready_s1           (wready_s1),
    .awvalid_s2          (awvalid_s2),
    .awready_s2          (awready_s2),
    .wdata_s2            (wdata_s2),
    .wstrb_s2            (wstrb_s2),
    .wlast_s2            (wlast_s2),
    .wvalid_s2           (wvalid_s2),
    .wready_s2           (wready_s2),
    .write_data_arb_lock (write_data_arb_lock)
  );

  b_router u_b_router (
    .write_data_arb_lock (write_data_arb_lock),
    .bresp_m             (bresp_m),
    .bvalid_m            (bvalid_m),
    .bready_m            (bready_m),
    .bresp_s0            (bresp_s0),
    .bvalid_s0           (bvalid_s0),
    .bready_s0           (bready_s0),
    .bresp_s1            (bresp_s1),
    .bvalid_s1           (bvalid_s1),
    .bready_s1           (bready_s1),
    .bresp_s2            (bresp_s2),
    .bvalid_s2           (bvalid_s2),
    .bready_s2           (bready_s2)
  );

endmodule

`default_nettype wire

/* hw/b_router.sv */
`default_nettype none

module b_router
  import axi_pkg::*;
(
  input  write_data_arb_lock_t write_data_arb_lock,
  // Master
  output axi_resp_t            bresp_m,
  output logic                 bvalid_m,
  input  logic                 bready_m,
  // Slave 0
  input  axi_resp_t            bresp_s0,
  input  logic                 bvalid_s0,
  output logic                 bready_s0,
  // Slave 1
  input  axi_resp_t            bresp_s1,
  input  logic                 bvalid_s1,
  output logic                 bready_s1,
  // Slave 2
  input  axi_resp_t            bresp_s2,
  input  logic                 bvalid_s2,
  output logic                 bready_s2
);

  logic [2:0] b_sel;

  // Response accepted only from the slave waiting on B
  always_comb begin
    case (write_data_arb_lock)
      WLOCK_S0_WRESP: b_sel = 3'b001;
      WLOCK_S1_WRESP: b_sel = 3'b010;
      WLOCK_S2_WRESP: b_sel = 3'b100;
      default:        b_sel = 3'b000;
    endcase
  end

  assign bvalid_m = |(b_sel & {bvalid_s2, bvalid_s1, bvalid_s0});

  always_comb begin
    case (b_sel)
      3'b001:  bresp_m = bresp_s0;
      3'b010:  bresp_m = bresp_s1;
      3'b100:  bresp_m = bresp_s2;
      default: bresp_m = '0;
    endcase
  end

  assign bready_s0 = b_sel[0] & bready_m;
  assign bready_s1 = b_sel[1] & bready_m;
  assign bready_s2 = b_sel[2] & bready_m;

endmodule

`default_nettype wire

/* hw/w_router.sv */
`default_nettype none

module w_router
  import axi_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  // Master W
  input  axi_data_t            wdata_m,
  input  axi_strb_t            wstrb_m,
  input  logic                 wlast_m,
  input  logic                 wvalid_m,
  output logic                 wready_m,
  // Master B handshake
  input  logic                 bvalid_m,
  input  logic                 bready_m,
  // Slave 0
  input  logic                 awvalid_s0,
  input  logic                 awready_s0,
  output axi_data_t            wdata_s0,
  output axi_strb_t            wstrb_s0,
  output logic                 wlast_s0,
  output logic                 wvalid_s0,
  input  logic                 wready_s0,
  // Slave 1
  input  logic                 awvalid_s1,
  input  logic                 awready_s1,
  output axi_data_t            wdata_s1,
  output axi_strb_t            wstrb_s1,
  output logic                 wlast_s1,
  output logic                 wvalid_s1,
  input  logic                 wready_s1,
  // Slave 2
  input  logic                 awvalid_s2,
  input  logic                 awready_s2,
  output axi_data_t            wdata_s2,
  output axi_strb_t            wstrb_s2,
  output logic                 wlast_s2,
  output logic                 wvalid_s2,
  input  logic                 wready_s2,
  // Lock
  output write_data_arb_lock_t write_data_arb_lock
);

  write_data_arb_lock_t lock_next;
  logic [2:0]           aw_hs;
  logic [2:0]           w_sel;
  logic                 last_hs;
  logic                 b_hs;

  assign aw_hs   = {awvalid_s2 & awready_s2, awvalid_s1 & awready_s1, awvalid_s0 & awready_s0};
  assign last_hs = wvalid_m & wready_m & wlast_m;
  assign b_hs    = bvalid_m & bready_m;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      write_data_arb_lock <= WLOCK_NO;
    end else begin
      write_data_arb_lock <= lock_next;
    end
  end

  always_comb begin
    lock_next = write_data_arb_lock;
    case (write_data_arb_lock)
      WLOCK_NO: begin
        if (aw_hs[0]) lock_next = WLOCK_S0;
        else if (aw_hs[1]) lock_next = WLOCK_S1;
        else if (aw_hs[2]) lock_next = WLOCK_S2;
      end
      WLOCK_S0: begin
        if (last_hs) lock_next = WLOCK_S0_WRESP;
      end
      WLOCK_S1: begin
        if (last_hs) lock_next = WLOCK_S1_WRESP;
      end
      WLOCK_S2: begin
        if (last_hs) lock_next = WLOCK_S2_WRESP;
      end
      WLOCK_S0_WRESP, WLOCK_S1_WRESP, WLOCK_S2_WRESP: begin
        // Write closes once the master takes B
        if (b_hs) lock_next = WLOCK_NO;
      end
      default: lock_next = WLOCK_NO;
    endcase
  end

  // Data phase only, nothing flows while waiting for B
  always_comb begin
    case (write_data_arb_lock)
      WLOCK_S0: w_sel = 3'b001;
      WLOCK_S1: w_sel = 3'b010;
      WLOCK_S2: w_sel = 3'b100;
      default:  w_sel = 3'b000;
    endcase
  end

  assign wvalid_s0 = w_sel[0] & wvalid_m;
  assign wvalid_s1 = w_sel[1] & wvalid_m;
  assign wvalid_s2 = w_sel[2] & wvalid_m;

  assign wlast_s0 = w_sel[0] & wlast_m;
  assign wlast_s1 = w_sel[1] & wlast_m;
  assign wlast_s2 = w_sel[2] & wlast_m;

  assign wdata_s0 = w_sel[0] ? wdata_m : '0;
  assign wdata_s1 = w_sel[1] ? wdata_m : '0;
  assign wdata_s2 = w_sel[2] ? wdata_m : '0;

  assign wstrb_s0 = w_sel[0] ? wstrb_m : '0;
  assign wstrb_s1 = w_sel[1] ? wstrb_m : '0;
  assign wstrb_s2 = w_sel[2] ? wstrb_m : '0;

  assign wready_m = |(w_sel & {wready_s2, wready_s1, wready_s0});

endmodule

`default_nettype wire

/* verif/axi_write_xbar_checker.sv */
`default_nettype none

module axi_write_xbar_checker
  import axi_pkg::*;
(
  input logic                 clk,
  input logic                 rstn,
  input write_data_arb_lock_t write_data_arb_lock,
  input logic                 awready_m,
  input logic                 bvalid_m,
  input logic                 wvalid_s0,
  input logic                 wvalid_s1,
  input logic                 wvalid_s2
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fails = 0;
  logic w_open;
  logic b_wait;

  assign w_open = write_data_arb_lock inside {WLOCK_S0, WLOCK_S1, WLOCK_S2};
  assign b_wait = write_data_arb_lock inside {WLOCK_S0_WRESP, WLOCK_S1_WRESP, WLOCK_S2_WRESP};

  // Data goes to one slave at most
  a_wvalid_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({wvalid_s2, wvalid_s1, wvalid_s0}))
    else begin
      fails++;
      $error("more than one wvalid_sx is high");
    end

  a_wvalid_locked: assert property (@(posedge clk) disable iff (!rstn)
    (wvalid_s0 || wvalid_s1 || wvalid_s2) |-> w_open)
    else begin
      fails++;
      $error("wvalid_sx is high outside a data lock");
    end

  a_awready_idle: assert property (@(posedge clk) disable iff (!rstn)
    awready_m |-> (write_data_arb_lock == WLOCK_NO))
    else begin
      fails++;
      $error("awready_m is high while a write is open");
    end

  a_bvalid_wresp: assert property (@(posedge clk) disable iff (!rstn)
    bvalid_m |-> b_wait)
    else begin
      fails++;
      $error("bvalid_m is high outside a response lock");
    end

endmodule

bind axi_write_xbar axi_write_xbar_checker u_checker (
  .clk                 (clk),
  .rstn                (rstn),
  .write_data_arb_lock (write_data_arb_lock),
  .awready_m           (awready_m),
  .bvalid_m            (bvalid_m),
  .wvalid_s0           (wvalid_s0),
  .wvalid_s1           (wvalid_s1),
  .wvalid_s2           (wvalid_s2)
);

`default_nettype wire

/* verif/axi_write_xbar_tb.sv */
`default_nettype none

`include "axi_consts.svh"

module axi_write_xbar_tb
  import axi_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int        WAIT_LIMIT  = 100;
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  logic      clk;
  logic      rstn;
  axi_addr_t awaddr_m;
  axi_len_t  awlen_m;
  logic      awvalid_m;
  logic      awready_m;
  axi_data_t wdata_m;
  axi_strb_t wstrb_m;
  logic      wlast_m;
  logic      wvalid_m;
  logic      wready_m;
  axi_resp_t bresp_m;
  logic      bvalid_m;
  logic      bready_m;

  // Slave side indexed by slave number
  axi_addr_t awaddr_s [3];
  axi_len_t  awlen_s [3];
  logic      awvalid_s [3];
  logic      awready_s [3];
  axi_data_t wdata_s [3];
  axi_strb_t wstrb_s [3];
  logic      wlast_s [3];
  logic      wvalid_s [3];
  logic      wready_s [3];
  axi_resp_t bresp_s [3];
  logic      bvalid_s [3];
  logic      bready_s [3];
  logic      spur_b [3];

  int        aw_dly [3];
  int        w_dly [3];
  int        b_dly [3];
  logic      b_pend [3];
  axi_addr_t rx_addr [3][$];
  axi_len_t  rx_len [3][$];
  axi_data_t rx_data [3][$];
  axi_strb_t rx_strb [3][$];
  logic      rx_last [3][$];

  int seed = 32'hb0a3;
  int errors;
  int tests_run;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  axi_write_xbar dut (
    .*,
    .awaddr_s0  (awaddr_s[0]),  .awaddr_s1  (awaddr_s[1]),  .awaddr_s2  (awaddr_s[2]),
    .awlen_s0   (awlen_s[0]),   .awlen_s1   (awlen_s[1]),   .awlen_s2   (awlen_s[2]),
    .awvalid_s0 (awvalid_s[0]), .awvalid_s1 (awvalid_s[1]), .awvalid_s2 (awvalid_s[2]),
    .awready_s0 (awready_s[0]), .awready_s1 (awready_s[1]), .awready_s2 (awready_s[2]),
    .wdata_s0   (wdata_s[0]),   .wdata_s1   (wdata_s[1]),   .wdata_s2   (wdata_s[2]),
    .wstrb_s0   (wstrb_s[0]),   .wstrb_s1   (wstrb_s[1]),   .wstrb_s2   (wstrb_s[2]),
    .wlast_s0   (wlast_s[0]),   .wlast_s1   (wlast_s[1]),   .wlast_s2   (wlast_s[2]),
    .wvalid_s0  (wvalid_s[0]),  .wvalid_s1  (wvalid_s[1]),  .wvalid_s2  (wvalid_s[2]),
    .wready_s0  (wready_s[0]),  .wready_s1  (wready_s[1]),  .wready_s2  (wready_s[2]),
    .bresp_s0   (bresp_s[0]),   .bresp_s1   (bresp_s[1]),   .bresp_s2   (bresp_s[2]),
    .bready_s0  (bready_s[0]),  .bready_s1  (bready_s[1]),  .bready_s2  (bready_s[2]),
    .bvalid_s0  (bvalid_s[0] | spur_b[0]),
    .bvalid_s1  (bvalid_s[1] | spur_b[1]),
    .bvalid_s2  (bvalid_s[2] | spur_b[2])
  );

  // Slave models with ready and response delays of 0 to 3 cycles
  always @(posedge clk, negedge rstn) begin
    int d;
    for (int i = 0; i < 3; i++) begin
      if (!rstn) begin
        awready_s[i] <= 1'b0;
        wready_s[i]  <= 1'b0;
        bvalid_s[i]  <= 1'b0;
        b_pend[i]    <= 1'b0;
        aw_dly[i]    <= $random(seed) & 3;
        w_dly[i]     <= $random(seed) & 3;
        b_dly[i]     <= 0;
      end else begin
        if (awvalid_s[i] && awready_s[i]) begin
          rx_addr[i].push_back(awaddr_s[i]);
          rx_len[i].push_back(awlen_s[i]);
          awready_s[i] <= 1'b0;
          aw_dly[i]    <= $random(seed) & 3;
        end else if (awvalid_s[i]) begin
          if (aw_dly[i] == 0) awready_s[i] <= 1'b1;
          else aw_dly[i] <= aw_dly[i] - 1;
        end
        if (wvalid_s[i] && wready_s[i]) begin
          rx_data[i].push_back(wdata_s[i]);
          rx_strb[i].push_back(wstrb_s[i]);
          rx_last[i].push_back(wlast_s[i]);
          d = $random(seed) & 3;
          w_dly[i]    <= d;
          wready_s[i] <= (d == 0);
          if (wlast_s[i]) begin
            b_pend[i] <= 1'b1;
            b_dly[i]  <= $random(seed) & 3;
          end
        end else if (wvalid_s[i]) begin
          if (w_dly[i] == 0) wready_s[i] <= 1'b1;
          else w_dly[i] <= w_dly[i] - 1;
        end
        if (bvalid_s[i] && bready_s[i]) begin
          bvalid_s[i] <= 1'b0;
        end else if (b_pend[i] && !bvalid_s[i]) begin
          if (b_dly[i] == 0) begin
            bvalid_s[i] <= 1'b1;
            b_pend[i]   <= 1'b0;
          end else begin
            b_dly[i] <= b_dly[i] - 1;
          end
        end
      end
    end
  end

  task automatic give_up(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Tests run: %0d, errors: %0d", tests_run, errors + 1);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_strb(input string name, input axi_strb_t exp, input axi_strb_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_slave(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("** Error %s: expected slave %0d, actual slave %0d", name, exp, act);
    end
  endtask

  task automatic expect_beats(input string name, input int slave, input int n);
    if (rx_data[slave].size() != n) begin
      errors++;
      $display("%s: slave %0d received %0d beats instead of %0d",
               name, slave, rx_data[slave].size(), n);
    end
  endtask

  // Slave that got beats, or -1 for none and 3 for several
  function automatic int receiver();
    int who;
    who = -1;
    for (int i = 0; i < 3; i++) begin
      if (rx_data[i].size() != 0) who = (who == -1) ? i : 3;
    end
    return who;
  endfunction

  task automatic clear_rx();
    for (int i = 0; i < 3; i++) begin
      rx_addr[i].delete();
      rx_len[i].delete();
      rx_data[i].delete();
      rx_strb[i].delete();
      rx_last[i].delete();
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    tests_run++;
    $display("%-16s %s", name, (errors == first_err) ? "ok" : "failed");
  endtask

  task automatic send_aw(input axi_addr_t addr, input axi_len_t len);
    int n;
    @(posedge clk);
    awaddr_m  <= addr;
    awlen_m   <= len;
    awvalid_m <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!awready_m && n < WAIT_LIMIT);
    if (!awready_m) give_up("awready_m");
    awvalid_m <= 1'b0;
  endtask

  // Beat k carries base + k
  task automatic send_w(input axi_data_t base, input axi_strb_t strb, input int beats);
    int n;
    @(posedge clk);
    for (int k = 0; k < beats; k++) begin
      wdata_m  <= base + k;
      wstrb_m  <= strb;
      wlast_m  <= (k == beats - 1);
      wvalid_m <= 1'b1;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!wready_m && n < WAIT_LIMIT);
      if (!wready_m) give_up("wready_m");
    end
    wvalid_m <= 1'b0;
    wlast_m  <= 1'b0;
  endtask

  task automatic take_b(output axi_resp_t resp);
    int n;
    @(posedge clk);
    bready_m <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!bvalid_m && n < WAIT_LIMIT);
    if (!bvalid_m) give_up("bvalid_m");
    resp = bresp_m;
    bready_m <= 1'b0;
  endtask

  task automatic write_burst(input axi_addr_t addr, input int beats, input axi_data_t base,
                             input axi_strb_t strb, output axi_resp_t resp);
    send_aw(addr, axi_len_t'(beats - 1));
    send_w(base, strb, beats);
    take_b(resp);
  endtask

  task automatic single_write(input int region, input string name);
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    axi_resp_t resp;
    int        exp_slave;
    addr      = (axi_addr_t'(region) << `AXI_SEL_LSB) | axi_addr_t'(32'h40);
    data      = 32'hc0de_0000 + region;
    strb      = axi_strb_t'(1 << region);
    exp_slave = (region == 3) ? 2 : region;
    clear_rx();
    write_burst(addr, 1, data, strb, resp);
    check_slave(name, exp_slave, receiver());
    expect_beats(name, exp_slave, 1);
    check_addr(name, addr, rx_addr[exp_slave][0]);
    check_len(name, axi_len_t'(0), rx_len[exp_slave][0]);
    check_data(name, data, rx_data[exp_slave][0]);
    check_strb(name, strb, rx_strb[exp_slave][0]);
  endtask

  task automatic w_without_aw();
    int e0;
    e0 = errors;
    clear_rx();
    @(posedge clk);
    wdata_m  <= 32'hdead_beef;
    wstrb_m  <= 4'hf;
    wvalid_m <= 1'b1;
    repeat (5) begin
      @(posedge clk);
      if (wvalid_s[0] || wvalid_s[1] || wvalid_s[2] || wready_m) begin
        errors++;
        $display("w_without_aw: a W beat moved before any AW handshake");
      end
    end
    wvalid_m <= 1'b0;
    check_slave("w_without_aw", -1, receiver());
    report_test("w_without_aw", e0);
  endtask

  task automatic write_each_region();
    int e0;
    e0 = errors;
    for (int r = 0; r < 3; r++) begin
      single_write(r, "regions");
    end
    report_test("regions", e0);
  endtask

  task automatic burst_to_slave1();
    axi_resp_t resp;
    int        e0;
    e0 = errors;
    clear_rx();
    write_burst(32'h0001_0100, 8, 32'h5a00_0000, 4'hf, resp);
    check_slave("burst", 1, receiver());
    expect_beats("burst", 1, 8);
    check_addr("burst", 32'h0001_0100, rx_addr[1][0]);
    check_len("burst", 8'd7, rx_len[1][0]);
    for (int k = 0; k < 8; k++) begin
      check_data("burst", 32'h5a00_0000 + k, rx_data[1][k]);
      check_strb("burst", 4'hf, rx_strb[1][k]);
      if (rx_last[1][k] !== (k == 7)) begin
        errors++;
        $display("burst: wlast is wrong on beat %0d", k);
      end
    end
    report_test("burst", e0);
  endtask

  task automatic region3_to_default();
    int e0;
    e0 = errors;
    single_write(3, "default_slave");
    report_test("default_slave", e0);
  endtask

  task automatic second_aw_blocked();
    axi_resp_t resp;
    time       b1_time;
    time       aw2_time;
    int        e0;
    e0 = errors;
    clear_rx();
    send_aw(32'h0000_0200, 0);
    fork
      begin
        send_w(32'h0a0a_0001, 4'hf, 1);
        take_b(resp);
        b1_time = $time;
      end
      begin
        send_aw(32'h0001_0300, 0);
        aw2_time = $time;
      end
    join
    if (aw2_time <= b1_time) begin
      errors++;
      $display("blocked_aw: second AW was accepted before the first write ended");
    end
    send_w(32'h0b0b_0002, 4'h3, 1);
    take_b(resp);
    expect_beats("blocked_aw", 0, 1);
    expect_beats("blocked_aw", 1, 1);
    check_addr("blocked_aw", 32'h0001_0300, rx_addr[1][0]);
    check_data("blocked_aw", 32'h0a0a_0001, rx_data[0][0]);
    check_data("blocked_aw", 32'h0b0b_0002, rx_data[1][0]);
    check_strb("blocked_aw", 4'h3, rx_strb[1][0]);
    report_test("blocked_aw", e0);
  endtask

  task automatic route_responses();
    axi_resp_t resp;
    int        e0;
    e0 = errors;
    @(posedge clk);
    bresp_s[0] <= RESP_OKAY;
    bresp_s[1] <= RESP_SLVERR;
    bresp_s[2] <= RESP_DECERR;
    spur_b[2]  <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      if (bvalid_m) begin
        errors++;
        $display("responses: a stray bvalid from slave 2 reached the master");
      end
    end
    write_burst(32'h0000_0010, 1, 32'h7700_0000, 4'hf, resp);
    check_resp("responses", RESP_OKAY, resp);
    write_burst(32'h0001_0010, 1, 32'h7700_0001, 4'hf, resp);
    check_resp("responses", RESP_SLVERR, resp);
    @(posedge clk);
    spur_b[2]  <= 1'b0;
    bresp_s[1] <= RESP_OKAY;
    bresp_s[2] <= RESP_OKAY;
    report_test("responses", e0);
  endtask

  initial begin
    rstn      = 1'b0;
    awaddr_m  = '0;
    awlen_m   = '0;
    awvalid_m = 1'b0;
    wdata_m   = '0;
    wstrb_m   = '0;
    wlast_m   = 1'b0;
    wvalid_m  = 1'b0;
    bready_m  = 1'b0;
    for (int i = 0; i < 3; i++) begin
      awready_s[i] = 1'b0;
      wready_s[i]  = 1'b0;
      bvalid_s[i]  = 1'b0;
      bresp_s[i]   = RESP_OKAY;
      spur_b[i]    = 1'b0;
    end
    errors    = 0;
    tests_run = 0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    w_without_aw();
    write_each_region();
    burst_to_slave1();
    region3_to_default();
    second_aw_blocked();
    route_responses();

    repeat (4) @(posedge clk);
    errors += dut.u_checker.fails;
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
